// File: project.f
verilog/bp_pkg.sv
verilog/branch_predictor_super.sv
verilog/branch_target_buffer.sv
verilog/fetch_next_pc.sv
verilog/fetch_predict_top.sv
tb/fetch_predict_props.sv
tb/fetch_predict_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f \
    --top-module fetch_predict_tb -o fetch_predict_sim

./obj_dir/fetch_predict_sim | tee sim.log || true

if grep -q "RESULT: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: tb/fetch_predict_props.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_predict_props #(
    parameter logic [bp_pkg::ADDR_WIDTH-1:0] RESET_PC = 32'h0000_1000
) (
    input wire logic                          clk,
    input wire logic                          reset,
    input wire logic                          redirect_valid,
    input wire logic [bp_pkg::ADDR_WIDTH-1:0] fetch_pc,
    input wire logic [bp_pkg::LANES-1:0]      slot_valid,
    input wire bp_pkg::npc_src_e              npc_src
);

    // The oldest slot of a group is never squashed
    a_first_slot_valid: assert property (@(posedge clk) disable iff (!reset)
        slot_valid[0])
        else $error("slot 0 of the fetch group is marked invalid");

    a_valid_mask_contiguous: assert property (@(posedge clk) disable iff (!reset)
        !(slot_valid[2] && !slot_valid[1]) && !(slot_valid[1] && !slot_valid[0]))
        else $error("slot_valid has a hole below a set bit");

    a_redirect_priority: assert property (@(posedge clk) disable iff (!reset)
        redirect_valid |-> npc_src == bp_pkg::npc_redirect)
        else $error("redirect given but npc_src does not select it");

    // First edge after reset release sees the reset address
    a_reset_pc: assert property (@(posedge clk)
        $rose(reset) |-> fetch_pc == RESET_PC)
        else $error("fetch_pc is not the reset address after reset release");

endmodule

`default_nettype wire

// File: tb/fetch_predict_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_predict_tb;

    localparam int          CLK_PERIOD   = 100;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          NUM_CYCLES   = 2000;
    localparam int          PRED_ENTRIES = 32;
    localparam int          BTB_ENTRIES  = 16;
    localparam int          TAG_SHIFT    = 2 + $clog2(BTB_ENTRIES);
    localparam logic [31:0] RESET_PC     = 32'h0000_1000;
    localparam logic [31:0] SEED         = 32'h3b2dabe7;

    logic                                   clk;
    logic                                   reset;
    logic [2:0]                             is_branch;
    bp_pkg::bp_update_t [bp_pkg::LANES-1:0] update;
    logic                                   redirect_valid;
    logic [31:0]                            redirect_pc;
    logic [31:0]                            fetch_pc;
    logic [2:0]                             slot_valid;
    logic [2:0]                             pred_taken;
    bp_pkg::npc_src_e                       npc_src;

    // Reference model state
    logic [1:0]  ctr_model [PRED_ENTRIES];
    logic [1:0]  ctr_next  [PRED_ENTRIES];
    logic        btb_valid [BTB_ENTRIES];
    logic [31:0] btb_pc    [BTB_ENTRIES];
    logic [31:0] btb_tgt   [BTB_ENTRIES];
    logic [31:0] exp_pc;
    logic [31:0] exp_next;

    fetch_predict_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .is_branch      (is_branch),
        .update         (update),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_pc       (fetch_pc),
        .slot_valid     (slot_valid),
        .pred_taken     (pred_taken),
        .npc_src        (npc_src)
    );

    bind fetch_next_pc fetch_predict_props #(
        .RESET_PC (RESET_PC)
    ) u_props (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .fetch_pc       (fetch_pc),
        .slot_valid     (slot_valid),
        .npc_src        (npc_src)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Model helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int pred_index(input logic [31:0] pc);
        return int'((pc >> 2) % PRED_ENTRIES);
    endfunction

    function automatic int btb_index(input logic [31:0] pc);
        return int'((pc >> 2) % BTB_ENTRIES);
    endfunction

    // 0 strong NT, 1 weak NT, 2 weak T, 3 strong T
    function automatic logic [1:0] step_counter(input logic [1:0] cur, input logic mis);
        logic [1:0] nxt;
        if (!mis) begin
            nxt = cur[1] ? 2'd3 : 2'd0;        // Confirmed, go strong
        end else if (cur == 2'd0 || cur == 2'd3) begin
            nxt = (cur == 2'd0) ? 2'd1 : 2'd2; // Strong weakens
        end else begin
            nxt = 2'd3 - cur;                   // Weak flips
        end
        return nxt;
    endfunction

    // Small pool so that entries alias and lanes collide
    function automatic logic [31:0] pool_pc();
        logic [31:0] base;
        case ($urandom % 3)
            0:       base = 32'h0000_1000;
            1:       base = 32'h0000_1040;  // Same BTB index, other tag
            default: base = 32'h0000_2000;
        endcase
        return base + ($urandom % 24) * 4;
    endfunction

    task automatic check_field(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus, checking and model update
    //////////////////////////////////////////////////////////////////////

    task automatic drive_random_inputs();
        is_branch = 3'($urandom);
        for (int l = 0; l < bp_pkg::LANES; l++) begin
            update[l].valid      = ($urandom % 4) != 0;
            update[l].pc         = pool_pc();
            update[l].mispredict = 1'($urandom);
            update[l].taken      = 1'($urandom);
            update[l].target     = 32'h0000_1000 + ($urandom % 32) * 4;
        end
        redirect_valid = ($urandom % 16) == 0;
        redirect_pc    = 32'h0000_1000 + ($urandom % 32) * 4;
    endtask

    task automatic check_outputs();
        logic [2:0]       exp_taken;
        logic [2:0]       exp_valid;
        logic             found;
        logic             hit;
        logic [31:0]      spc;
        logic [31:0]      tgt;
        bp_pkg::npc_src_e exp_src;
        exp_taken = '0;
        exp_valid = '0;
        found     = 1'b0;
        tgt       = '0;
        for (int i = 0; i < bp_pkg::LANES; i++) begin
            spc          = exp_pc + 32'(4 * i);
            exp_taken[i] = is_branch[i] && (ctr_model[pred_index(spc)] >= 2'd2);
            hit = btb_valid[btb_index(spc)] &&
                  ((btb_pc[btb_index(spc)] >> TAG_SHIFT) == (spc >> TAG_SHIFT));
            if (!found) begin
                exp_valid[i] = 1'b1;
                if (exp_taken[i] && hit) begin
                    found = 1'b1;
                    tgt   = btb_tgt[btb_index(spc)];
                end
            end
        end
        if (redirect_valid) begin
            exp_src  = bp_pkg::npc_redirect;
            exp_next = redirect_pc;
        end else if (found) begin
            exp_src  = bp_pkg::npc_pred;
            exp_next = tgt;
        end else begin
            exp_src  = bp_pkg::npc_seq;
            exp_next = exp_pc + 32'd12;
        end
        check_field("fetch_pc", fetch_pc, exp_pc);
        check_field("pred_taken", 32'(pred_taken), 32'(exp_taken));
        check_field("slot_valid", 32'(slot_valid), 32'(exp_valid));
        check_field("npc_src", 32'(npc_src), 32'(exp_src));
    endtask

    // Every lane steps from the old counter, so the last lane wins
    task automatic advance_model();
        ctr_next = ctr_model;
        for (int l = 0; l < bp_pkg::LANES; l++) begin
            if (update[l].valid) begin
                ctr_next[pred_index(update[l].pc)] =
                    step_counter(ctr_model[pred_index(update[l].pc)], update[l].mispredict);
            end
            if (update[l].valid && update[l].taken) begin
                btb_valid[btb_index(update[l].pc)] = 1'b1;
                btb_pc[btb_index(update[l].pc)]    = update[l].pc;
                btb_tgt[btb_index(update[l].pc)]   = update[l].target;
            end
        end
        ctr_model = ctr_next;
        exp_pc    = exp_next;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        clk            = 1'b0;
        reset          = 1'b0;
        is_branch      = '0;
        update         = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        for (int e = 0; e < PRED_ENTRIES; e++) begin
            ctr_model[e] = 2'd2;    // Weak taken
        end
        for (int e = 0; e < BTB_ENTRIES; e++) begin
            btb_valid[e] = 1'b0;
            btb_pc[e]    = '0;
            btb_tgt[e]   = '0;
        end
        exp_pc = RESET_PC;
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b1;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            drive_random_inputs();
            #(CLK_PERIOD - DRIVE_DELAY - 2);    // Just before the edge
            check_outputs();
            advance_model();
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #((NUM_CYCLES + 100) * CLK_PERIOD);
        $display("Timeout: the test did not finish within the expected number of cycles");
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// File: verilog/bp_pkg.sv
`default_nettype none

package bp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes shared by the whole front end
    //////////////////////////////////////////////////////////////////////

    localparam int LANES      = 3;   // Fetch slots and update lanes per cycle
    localparam int ADDR_WIDTH = 32;  // RV32I instruction address

    //////////////////////////////////////////////////////////////////////
    // Enumerations
    //////////////////////////////////////////////////////////////////////

    // Direction counter whose upper bit is the prediction
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } ctr_state_e;

    // Source of the next fetch address
    typedef enum logic [1:0] {
        npc_seq      = 2'b00,
        npc_pred     = 2'b01,
        npc_redirect = 2'b10
    } npc_src_e;

    //////////////////////////////////////////////////////////////////////
    // Structures
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] pc;
        logic                  is_branch;  // Set by the front end decode
    } fetch_slot_t;

    // One resolved branch from execute
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] pc;
        logic                  mispredict;
        logic                  taken;      // Resolved direction
        logic [ADDR_WIDTH-1:0] target;
    } bp_update_t;

    // Per-slot lookup result
    typedef struct packed {
        logic                  taken;      // From the direction table
        logic                  hit;        // From the BTB
        logic [ADDR_WIDTH-1:0] target;
    } slot_pred_t;

endpackage

`default_nettype wire

// File: verilog/branch_predictor_super.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_super #(
    parameter int PRED_ENTRIES = 32
) (
    input  wire logic                                      clk,
    input  wire logic                                      reset,
    input  wire bp_pkg::fetch_slot_t [bp_pkg::LANES-1:0]   slot,
    input  wire bp_pkg::bp_update_t  [bp_pkg::LANES-1:0]   update,
    output logic                     [bp_pkg::LANES-1:0]   pred_taken
);

    localparam int IDX_W = $clog2(PRED_ENTRIES);

    //////////////////////////////////////////////////////////////////////
    // Counter table
    //////////////////////////////////////////////////////////////////////

    bp_pkg::ctr_state_e ctr_table [PRED_ENTRIES];

    logic [IDX_W-1:0] pred_idx [bp_pkg::LANES];
    logic [IDX_W-1:0] upd_idx  [bp_pkg::LANES];

    // Word index, byte offset dropped
    function automatic logic [IDX_W-1:0] idx_of(input logic [bp_pkg::ADDR_WIDTH-1:0] pc);
        return pc[IDX_W+1:2];
    endfunction

    // Saturating step driven by the misprediction flag
    function automatic bp_pkg::ctr_state_e next_ctr(
        input bp_pkg::ctr_state_e cur,
        input logic               mispredict
    );
        bp_pkg::ctr_state_e nxt;
        nxt = cur;
        case (cur)
            bp_pkg::strong_not_taken: begin
                if (mispredict) begin
                    nxt = bp_pkg::weak_not_taken;
                end
            end
            bp_pkg::weak_not_taken: begin
                if (mispredict) begin
                    nxt = bp_pkg::weak_taken;        // Flip direction
                end else begin
                    nxt = bp_pkg::strong_not_taken;
                end
            end
            bp_pkg::weak_taken: begin
                if (mispredict) begin
                    nxt = bp_pkg::weak_not_taken;    // Flip direction
                end else begin
                    nxt = bp_pkg::strong_taken;
                end
            end
            bp_pkg::strong_taken: begin
                if (mispredict) begin
                    nxt = bp_pkg::weak_taken;
                end
            end
            default: nxt = bp_pkg::weak_taken;
        endcase
        return nxt;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Prediction, combinational in the fetch cycle
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < bp_pkg::LANES; i++) begin
            pred_idx[i] = idx_of(slot[i].pc);
            upd_idx[i]  = idx_of(update[i].pc);
        end
    end

    always_comb begin
        for (int i = 0; i < bp_pkg::LANES; i++) begin
            // Non-branch slots never predict taken
            pred_taken[i] = slot[i].is_branch & ctr_table[pred_idx[i]][1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Training from execute
    //////////////////////////////////////////////////////////////////////

    // Each lane steps from the old value; later lanes overwrite earlier ones
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int e = 0; e < PRED_ENTRIES; e++) begin
                ctr_table[e] <= bp_pkg::weak_taken;
            end
        end else begin
            for (int l = 0; l < bp_pkg::LANES; l++) begin
                if (update[l].valid) begin
                    ctr_table[upd_idx[l]] <= next_ctr(ctr_table[upd_idx[l]],
                                                      update[l].mispredict);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_ENTRIES = 16
) (
    input  wire logic                                             clk,
    input  wire logic                                             reset,
    input  wire logic [bp_pkg::LANES-1:0][bp_pkg::ADDR_WIDTH-1:0] slot_pc,
    input  wire bp_pkg::bp_update_t [bp_pkg::LANES-1:0]           update,
    output logic      [bp_pkg::LANES-1:0]                         btb_hit,
    output logic      [bp_pkg::LANES-1:0][bp_pkg::ADDR_WIDTH-1:0] btb_target
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = bp_pkg::ADDR_WIDTH - IDX_W - 2;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    logic [BTB_ENTRIES-1:0]        entry_valid;
    logic [TAG_W-1:0]              entry_tag    [BTB_ENTRIES];
    logic [bp_pkg::ADDR_WIDTH-1:0] entry_target [BTB_ENTRIES];

    logic [IDX_W-1:0] look_idx [bp_pkg::LANES];
    logic [TAG_W-1:0] look_tag [bp_pkg::LANES];
    logic [IDX_W-1:0] wr_idx   [bp_pkg::LANES];
    logic [bp_pkg::LANES-1:0] wr_en;

    function automatic logic [IDX_W-1:0] idx_of(input logic [bp_pkg::ADDR_WIDTH-1:0] pc);
        return pc[IDX_W+1:2];
    endfunction

    // Everything above the index
    function automatic logic [TAG_W-1:0] tag_of(input logic [bp_pkg::ADDR_WIDTH-1:0] pc);
        return pc[bp_pkg::ADDR_WIDTH-1:IDX_W+2];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < bp_pkg::LANES; i++) begin
            look_idx[i]   = idx_of(slot_pc[i]);
            look_tag[i]   = tag_of(slot_pc[i]);
            btb_hit[i]    = entry_valid[look_idx[i]] && (entry_tag[look_idx[i]] == look_tag[i]);
            btb_target[i] = entry_target[look_idx[i]];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Allocation on taken branches
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int l = 0; l < bp_pkg::LANES; l++) begin
            wr_idx[l] = idx_of(update[l].pc);
            wr_en[l]  = update[l].valid & update[l].taken;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            entry_valid <= '0;
        end else begin
            for (int l = 0; l < bp_pkg::LANES; l++) begin
                if (wr_en[l]) begin
                    entry_valid[wr_idx[l]] <= 1'b1;
                end
            end
        end
    end

    // Highest lane is written last and wins
    always_ff @(posedge clk) begin
        for (int l = 0; l < bp_pkg::LANES; l++) begin
            if (wr_en[l]) begin
                entry_tag[wr_idx[l]]    <= tag_of(update[l].pc);
                entry_target[wr_idx[l]] <= update[l].target;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_next_pc.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_next_pc #(
    parameter logic [bp_pkg::ADDR_WIDTH-1:0] RESET_PC = 32'h0000_1000
) (
    input  wire logic                                             clk,
    input  wire logic                                             reset,
    input  wire logic [bp_pkg::LANES-1:0]                         pred_taken,
    input  wire logic [bp_pkg::LANES-1:0]                         btb_hit,
    input  wire logic [bp_pkg::LANES-1:0][bp_pkg::ADDR_WIDTH-1:0] btb_target,
    input  wire logic                                             redirect_valid,
    input  wire logic [bp_pkg::ADDR_WIDTH-1:0]                    redirect_pc,
    output logic      [bp_pkg::ADDR_WIDTH-1:0]                    fetch_pc,
    output logic      [bp_pkg::LANES-1:0]                         slot_valid,
    output bp_pkg::npc_src_e                                      npc_src
);

    localparam logic [bp_pkg::ADDR_WIDTH-1:0] GROUP_BYTES = bp_pkg::LANES * 4;

    bp_pkg::slot_pred_t [bp_pkg::LANES-1:0] slot_res;

    logic                          taken_found;
    logic [bp_pkg::ADDR_WIDTH-1:0] taken_target;
    logic [bp_pkg::ADDR_WIDTH-1:0] next_pc;

    //////////////////////////////////////////////////////////////////////
    // First taken slot
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < bp_pkg::LANES; i++) begin
            slot_res[i].taken  = pred_taken[i];
            slot_res[i].hit    = btb_hit[i];
            slot_res[i].target = btb_target[i];
        end
    end

    // Slots behind the taken one are dropped from the group
    always_comb begin
        taken_found  = 1'b0;
        taken_target = '0;
        slot_valid   = '0;
        for (int i = 0; i < bp_pkg::LANES; i++) begin
            if (!taken_found) begin
                slot_valid[i] = 1'b1;
                if (slot_res[i].taken && slot_res[i].hit) begin
                    taken_found  = 1'b1;
                    taken_target = slot_res[i].target;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next address select and PC register
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (redirect_valid) begin
            npc_src = bp_pkg::npc_redirect;      // Execute always wins
        end else if (taken_found) begin
            npc_src = bp_pkg::npc_pred;
        end else begin
            npc_src = bp_pkg::npc_seq;
        end
        case (npc_src)
            bp_pkg::npc_redirect: next_pc = redirect_pc;
            bp_pkg::npc_pred:     next_pc = taken_target;
            default:              next_pc = fetch_pc + GROUP_BYTES;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            fetch_pc <= RESET_PC;
        end else begin
            fetch_pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_predict_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_predict_top #(
    parameter int                            PRED_ENTRIES = 32,
    parameter int                            BTB_ENTRIES  = 16,
    parameter logic [bp_pkg::ADDR_WIDTH-1:0] RESET_PC     = 32'h0000_1000
) (
    input  wire logic                                   clk,
    input  wire logic                                   reset,
    input  wire logic [bp_pkg::LANES-1:0]               is_branch,
    input  wire bp_pkg::bp_update_t [bp_pkg::LANES-1:0] update,
    input  wire logic                                   redirect_valid,
    input  wire logic [bp_pkg::ADDR_WIDTH-1:0]          redirect_pc,
    output logic      [bp_pkg::ADDR_WIDTH-1:0]          fetch_pc,
    output logic      [bp_pkg::LANES-1:0]               slot_valid,
    output logic      [bp_pkg::LANES-1:0]               pred_taken,
    output bp_pkg::npc_src_e                            npc_src
);

    bp_pkg::fetch_slot_t [bp_pkg::LANES-1:0]                   slot;
    logic [bp_pkg::LANES-1:0][bp_pkg::ADDR_WIDTH-1:0]           slot_pc;
    logic [bp_pkg::LANES-1:0]                                  btb_hit;
    logic [bp_pkg::LANES-1:0][bp_pkg::ADDR_WIDTH-1:0]           btb_target;

    // Slot i sits at fetch_pc + 4*i
    always_comb begin
        for (int i = 0; i < bp_pkg::LANES; i++) begin
            slot_pc[i]        = fetch_pc + bp_pkg::ADDR_WIDTH'(4 * i);
            slot[i].pc        = slot_pc[i];
            slot[i].is_branch = is_branch[i];
        end
    end

    branch_predictor_super #(
        .PRED_ENTRIES (PRED_ENTRIES)
    ) u_pred (
        .clk        (clk),
        .reset      (reset),
        .slot       (slot),
        .update     (update),
        .pred_taken (pred_taken)
    );

    branch_target_buffer #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .clk        (clk),
        .reset      (reset),
        .slot_pc    (slot_pc),
        .update     (update),
        .btb_hit    (btb_hit),
        .btb_target (btb_target)
    );

    fetch_next_pc #(
        .RESET_PC (RESET_PC)
    ) u_npc (
        .clk            (clk),
        .reset          (reset),
        .pred_taken     (pred_taken),
        .btb_hit        (btb_hit),
        .btb_target     (btb_target),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_pc       (fetch_pc),
        .slot_valid     (slot_valid),
        .npc_src        (npc_src)
    );

endmodule

`default_nettype wire
